/* verilog/peak_pkg.sv */
`default_nettype none

package peak_pkg;

    ////////////////////
    // widths and frame geometry
    ////////////////////

    localparam int FLOAT_W       = 32;
    localparam int EXP_W         = 8;   // ieee single exponent
    localparam int MAN_W         = 23;  // ieee single mantissa
    localparam int POS_W         = 8;
    localparam int FILTER_POINTS = 128; // bins per frame
    localparam int NUM_PEAKS     = 3;

    ////////////////////
    // shared types
    ////////////////////

    typedef logic [FLOAT_W-1:0] float_t;
    typedef logic [POS_W-1:0]   pos_t;

    // one magnitude with its bin
    typedef struct packed {
        float_t mag;
        pos_t   pos;
    } sample_t;

    // band window for one ranked peak
    typedef struct packed {
        pos_t start_pos;
        pos_t end_pos;
        logic error;     // window runs past a frame edge
    } window_t;

    // index 0 holds the largest peak
    typedef window_t [NUM_PEAKS-1:0] window_array_t;
    typedef sample_t [NUM_PEAKS-1:0] slot_array_t;

endpackage

`default_nettype wire

/* verilog/float_compare.sv */
`default_nettype none

module float_compare
    import peak_pkg::*;
(
    input  float_t a,
    input  float_t b,
    output logic   greater,
    output logic   equal
);

    logic             a_sign;
    logic             b_sign;
    logic [EXP_W-1:0] a_exp;
    logic [EXP_W-1:0] b_exp;
    logic [MAN_W-1:0] a_man;
    logic [MAN_W-1:0] b_man;
    logic             both_zero;
    logic             mag_gt;
    logic             mag_lt;

    assign a_sign = a[FLOAT_W-1];
    assign b_sign = b[FLOAT_W-1];
    assign a_exp  = a[FLOAT_W-2 -: EXP_W];
    assign b_exp  = b[FLOAT_W-2 -: EXP_W];
    assign a_man  = a[MAN_W-1:0];
    assign b_man  = b[MAN_W-1:0];

    // +0 and -0 are the same value
    assign both_zero = (a[FLOAT_W-2:0] == '0) && (b[FLOAT_W-2:0] == '0);

    // exponent first, mantissa breaks the tie
    assign mag_gt = (a_exp > b_exp) || ((a_exp == b_exp) && (a_man > b_man));
    assign mag_lt = (a_exp < b_exp) || ((a_exp == b_exp) && (a_man < b_man));

    always_comb
    begin
        if (both_zero)
        begin
            greater = 1'b0;
        end
        else if (a_sign != b_sign)
        begin
            greater = !a_sign; // positive side wins
        end
        else if (a_sign)
        begin
            greater = mag_lt;  // both negative, order flips
        end
        else
        begin
            greater = mag_gt;
        end
    end

    assign equal = both_zero || (a == b);

endmodule

`default_nettype wire

/* verilog/local_peak_detect.sv */
`default_nettype none

module local_peak_detect
    import peak_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample,
    input  logic    sample_en,
    input  logic    frame_done,
    output sample_t peak,
    output logic    peak_en
);

    // how many samples of the current frame sit in the window
    typedef enum logic [1:0] {
        FILL_EMPTY,
        FILL_ONE,
        FILL_FULL
    } fill_state_t;

    fill_state_t fill_q;
    sample_t     prev_q;      // sample k-1
    sample_t     mid_q;       // sample k, the candidate
    logic        mid_gt_prev;
    logic        mid_gt_next;
    logic        is_peak;

    ////////////////////
    // neighbour compares
    ////////////////////

    float_compare i_cmp_prev (
        .a       (mid_q.mag),
        .b       (prev_q.mag),
        .greater (mid_gt_prev),
        .equal   ()
    );

    float_compare i_cmp_next (
        .a       (mid_q.mag),
        .b       (sample.mag),  // incoming k+1
        .greater (mid_gt_next),
        .equal   ()
    );

    // strictly above both sides, plateaus never qualify
    assign is_peak = sample_en && (fill_q == FILL_FULL) && mid_gt_prev && mid_gt_next;

    ////////////////////
    // window control
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fill_q  <= FILL_EMPTY;
            peak_en <= 1'b0;
        end
        else
        begin
            peak_en <= is_peak;
            if (frame_done)
            begin
                fill_q <= FILL_EMPTY; // next frame starts clean
            end
            else if (sample_en)
            begin
                case (fill_q)
                    FILL_EMPTY: fill_q <= FILL_ONE;
                    FILL_ONE:   fill_q <= FILL_FULL;
                    default:    fill_q <= FILL_FULL;
                endcase
            end
        end
    end

    // sample shift and peak capture
    always_ff @(posedge clk)
    begin
        if (sample_en)
        begin
            prev_q <= mid_q;
            mid_q  <= sample;
        end
        if (is_peak)
        begin
            peak <= mid_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/top3_peak_sort.sv */
`default_nettype none

module top3_peak_sort
    import peak_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sample_t     peak,
    input  logic        peak_en,
    input  logic        frame_done,
    output slot_array_t slots
);

    slot_array_t            slots_q;
    slot_array_t            slots_next;
    logic [NUM_PEAKS-1:0]   peak_gt;     // new peak beats slot i
    logic [NUM_PEAKS-1:1]   shift_down;  // slot i takes slot i-1

    ////////////////////
    // insertion network
    ////////////////////

    // slots stay ordered so the first hit from the top is the insert point
    for (genvar g = 0; g < NUM_PEAKS; g++)
    begin : g_slot
        float_compare i_cmp (
            .a       (peak.mag),
            .b       (slots_q[g].mag),
            .greater (peak_gt[g]),
            .equal   ()
        );

        if (g == 0)
        begin : g_top
            assign slots_next[g] = peak_gt[g] ? peak : slots_q[g];
        end
        else
        begin : g_lower
            // inserted somewhere above, so this slot moves down one
            assign shift_down[g] = |peak_gt[g-1:0];
            assign slots_next[g] = shift_down[g] ? slots_q[g-1] :
                                   peak_gt[g]    ? peak         :
                                                   slots_q[g];
        end
    end

    ////////////////////
    // slot registers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slots_q <= '0;
        end
        else if (frame_done)
        begin
            slots_q <= '0; // wins over a peak in the same cycle
        end
        else if (peak_en)
        begin
            slots_q <= slots_next;
        end
    end

    // equal values never displace, so older peaks stay above
    assign slots = slots_q;

endmodule

`default_nettype wire

/* verilog/band_window_gen.sv */
`default_nettype none

module band_window_gen
    import peak_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  slot_array_t   slots,
    input  pos_t          band_width,
    input  logic          frame_done,
    output window_array_t windows,
    output logic          window_en
);

    window_array_t win_next;

    ////////////////////
    // per-slot window math
    ////////////////////

    for (genvar g = 0; g < NUM_PEAKS; g++)
    begin : g_win
        pos_t           p;
        logic [POS_W:0] room;   // bins left up to the frame end

        assign p    = slots[g].pos;
        assign room = (POS_W+1)'(FILTER_POINTS) - {1'b0, p};

        // clip at bin 0
        assign win_next[g].start_pos = (p > band_width) ? p - band_width : '0;
        assign win_next[g].end_pos   = p + band_width; // wraps mod 256

        assign win_next[g].error = ({1'b0, p} < {1'b0, band_width})
                                 || (room < {1'b0, band_width});
    end

    ////////////////////
    // output registers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            windows   <= '0;
            window_en <= 1'b0;
        end
        else
        begin
            window_en <= frame_done;   // one cycle after finish
            if (frame_done)
            begin
                windows <= win_next;   // held until the next frame ends
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/spectrum_peak_finder.sv */
`default_nettype none

module spectrum_peak_finder
    import peak_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  sample_t       sample,
    input  logic          sample_en,
    input  logic          frame_done,
    input  pos_t          band_width,
    output window_array_t windows,
    output logic          window_en
);

    sample_t     peak;
    logic        peak_en;
    slot_array_t slots;

    ////////////////////
    // detect -> rank -> window
    ////////////////////

    local_peak_detect i_detect (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample),
        .sample_en  (sample_en),
        .frame_done (frame_done),
        .peak       (peak),
        .peak_en    (peak_en)
    );

    top3_peak_sort i_sort (
        .clk        (clk),
        .rst_n      (rst_n),
        .peak       (peak),
        .peak_en    (peak_en),
        .frame_done (frame_done),
        .slots      (slots)
    );

    // samples the slots before the sorter clears them
    band_window_gen i_window (
        .clk        (clk),
        .rst_n      (rst_n),
        .slots      (slots),
        .band_width (band_width),
        .frame_done (frame_done),
        .windows    (windows),
        .window_en  (window_en)
    );

endmodule

`default_nettype wire

/* verif/spectrum_peak_finder_tb.sv */
`default_nettype none

module spectrum_peak_finder_tb
    import peak_pkg::*;
();

    localparam int SEED            = 8146;
    localparam int RANDOM_FRAMES   = 20;
    localparam int DIRECTED_FRAMES = 6;
    localparam int TOTAL_FRAMES    = RANDOM_FRAMES + DIRECTED_FRAMES;
    localparam int TIMEOUT_CYCLES  = TOTAL_FRAMES * 400 + 100;

    logic          clk;
    logic          rst_n;
    sample_t       sample;
    logic          sample_en;
    logic          frame_done;
    pos_t          band_width;
    window_array_t windows;
    logic          window_en;

    logic [31:0]   lcg_state;
    logic          done_q;        // frame_done seen at the last edge
    int            cycle_count;
    window_array_t last_windows;  // result that windows must still hold
    float_t        frame_mag [FILTER_POINTS];

    spectrum_peak_finder i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample),
        .sample_en  (sample_en),
        .frame_done (frame_done),
        .band_width (band_width),
        .windows    (windows),
        .window_en  (window_en)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    ////////////////////
    // random numbers
    ////////////////////

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only since the low ones repeat quickly
    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = lcg_step();
        return lo + int'(r[31:8] % 24'(hi - lo + 1));
    endfunction

    function automatic float_t rand_float(input int exp_lo, input int exp_hi, input bit signed_ok);
        logic [31:0] r;
        logic        s;
        logic [7:0]  e;
        r = lcg_step();
        s = signed_ok ? r[31] : 1'b0;
        e = 8'(rand_range(exp_lo, exp_hi));
        r = lcg_step();
        return {s, e, r[31:9]};
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // single to double by hand for normal values and zeros
    function automatic real to_real(input float_t f);
        logic [63:0] d;
        if (f[30:0] == '0)
        begin
            return 0.0;  // +0 and -0 alike
        end
        d = {f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0};
        return $bitstoreal(d);
    endfunction

    function automatic bit mag_greater(input float_t a, input float_t b);
        return to_real(a) > to_real(b);
    endfunction

    function automatic window_array_t expected_windows(input pos_t w);
        window_array_t exp_win;
        float_t        slot_mag [NUM_PEAKS];
        pos_t          slot_pos [NUM_PEAKS];
        int            ins;
        int            p;
        int            wi;
        for (int i = 0; i < NUM_PEAKS; i++)
        begin
            slot_mag[i] = '0;
            slot_pos[i] = '0;
        end
        for (int k = 1; k < FILTER_POINTS - 1; k++)
        begin
            if (mag_greater(frame_mag[k], frame_mag[k-1]) &&
                mag_greater(frame_mag[k], frame_mag[k+1]))
            begin
                ins = NUM_PEAKS;
                for (int i = NUM_PEAKS - 1; i >= 0; i--)
                begin
                    if (mag_greater(frame_mag[k], slot_mag[i]))
                    begin
                        ins = i;  // ties stay above the newcomer
                    end
                end
                for (int i = NUM_PEAKS - 1; i > ins; i--)
                begin
                    slot_mag[i] = slot_mag[i-1];
                    slot_pos[i] = slot_pos[i-1];
                end
                if (ins < NUM_PEAKS)
                begin
                    slot_mag[ins] = frame_mag[k];
                    slot_pos[ins] = pos_t'(k);
                end
            end
        end
        wi = int'(w);
        for (int i = 0; i < NUM_PEAKS; i++)
        begin
            p = int'(slot_pos[i]);
            exp_win[i].start_pos = (p > wi) ? pos_t'(p - wi) : '0;
            exp_win[i].end_pos   = pos_t'((p + wi) % 256);
            exp_win[i].error     = (p < wi) || ((FILTER_POINTS - p) < wi);
        end
        return exp_win;
    endfunction

    ////////////////////
    // frame builders
    ////////////////////

    task automatic random_frame();
        for (int k = 0; k < FILTER_POINTS; k++)
        begin
            frame_mag[k] = rand_float(1, 254, 1'b1);
        end
    endtask

    // few distinct values plus both zeros, so plateaus and equal peaks show up
    task automatic pool_frame();
        float_t pool [6];
        for (int i = 0; i < 4; i++)
        begin
            pool[i] = rand_float(1, 254, 1'b1);
        end
        pool[4] = {1'b0, 31'd0};  // +0
        pool[5] = {1'b1, 31'd0};  // -0
        for (int k = 0; k < FILTER_POINTS; k++)
        begin
            frame_mag[k] = pool[rand_range(0, 5)];
        end
    endtask

    task automatic level_frame(input int exp_lo, input int exp_hi);
        for (int k = 0; k < FILTER_POINTS; k++)
        begin
            frame_mag[k] = rand_float(exp_lo, exp_hi, 1'b0);
        end
    endtask

    task automatic ramp_frame();
        for (int k = 0; k < FILTER_POINTS; k++)
        begin
            frame_mag[k] = {1'b0, 8'd100, 23'(k * 1000)};  // strictly rising
        end
    endtask

    task automatic lone_peak_frame();
        for (int k = 0; k < FILTER_POINTS; k++)
        begin
            frame_mag[k] = {1'b0, 8'd120, 23'd0};
        end
        frame_mag[rand_range(10, 117)] = rand_float(130, 200, 1'b0);
    endtask

    task automatic edge_frame();
        for (int k = 0; k < FILTER_POINTS; k++)
        begin
            frame_mag[k] = {1'b0, 8'd60, 23'd0};
        end
        frame_mag[1]   = {1'b0, 8'd200, 23'(rand_range(0, 1000))};
        frame_mag[3]   = {1'b0, 8'd180, 23'd0};
        frame_mag[126] = {1'b0, 8'd190, 23'd0};
    endtask

    ////////////////////
    // frame driver
    ////////////////////

    task automatic send_frame(input pos_t w);
        window_array_t exp_win;
        exp_win = expected_windows(w);
        band_width = w;
        for (int k = 0; k < FILTER_POINTS; k++)
        begin
            sample.mag = frame_mag[k];
            sample.pos = pos_t'(k);
            sample_en  = 1'b1;
            @(posedge clk);
            #1;
            sample_en = 1'b0;
            if (rand_range(0, 2) == 0)
            begin
                @(posedge clk);  // idle gap
                #1;
            end
        end
        repeat (rand_range(2, 4))
        begin
            @(posedge clk);
            #1;
        end
        // previous result must survive the whole frame
        assert (windows === last_windows)
        else
        begin
            $display("Fail windows: got 0x%h, expected 0x%h", windows, last_windows);
            stop_on_error();
        end
        frame_done = 1'b1;
        @(posedge clk);
        #1;
        frame_done = 1'b0;
        while (window_en !== 1'b1)
        begin
            @(posedge clk);
            #1;
        end
        assert (windows === exp_win)
        else
        begin
            $display("Fail windows: got 0x%h, expected 0x%h", windows, exp_win);
            stop_on_error();
        end
        last_windows = exp_win;
    endtask

    ////////////////////
    // monitors
    ////////////////////

    always @(posedge clk)
    begin
        done_q      <= frame_done;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    // window_en high exactly one cycle after each frame_done
    always @(negedge clk)
    begin
        assert (window_en === done_q)
        else
        begin
            $display("Fail window_en: got 0x%h, expected 0x%h", window_en, done_q);
            stop_on_error();
        end
    end

    initial
    begin
        rst_n        = 1'b0;
        sample       = '0;
        sample_en    = 1'b0;
        frame_done   = 1'b0;
        band_width   = '0;
        lcg_state    = SEED;
        done_q       = 1'b0;
        cycle_count  = 0;
        last_windows = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int f = 0; f < RANDOM_FRAMES; f++)
        begin
            if (f % 4 == 3)
            begin
                pool_frame();
            end
            else
            begin
                random_frame();
            end
            send_frame(pos_t'(rand_range(0, 40)));
        end

        ramp_frame();
        send_frame(pos_t'(17));
        lone_peak_frame();
        send_frame('0);
        lone_peak_frame();
        send_frame(pos_t'(rand_range(1, 40)));
        edge_frame();
        send_frame(8'd200);     // clips the start and wraps the end
        level_frame(200, 254);
        send_frame(pos_t'(rand_range(0, 40)));
        level_frame(1, 20);     // must not see the big values before it
        send_frame(pos_t'(rand_range(0, 40)));

        repeat (2) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/peak_pkg.sv
verilog/float_compare.sv
verilog/local_peak_detect.sv
verilog/top3_peak_sort.sv
verilog/band_window_gen.sv
verilog/spectrum_peak_finder.sv
verif/spectrum_peak_finder_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the spectrum peak finder testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=spectrum_peak_finder_tb
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
